/* fetch.f */
+incdir+.
fetch_pkg.sv
fetch_icache.sv
fetch_ifu.sv
fetch_top.sv
tb_axi_mem.sv
tb_fetch.sv

/* fetch_icache.sv */
`default_nettype none

`include "fetch_settings.svh"

module fetch_icache (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         lookup_req,
    input  wire  [31:0]                 lookup_addr,
    output logic                        hit,
    output logic [31:0]                 word,
    input  wire                         fill_valid,
    input  wire  [31:0]                 fill_addr,
    input  wire  fetch_pkg::cache_line_t fill_line
);
    import fetch_pkg::*;

    localparam int LINES  = `FETCH_CACHE_LINES;
    localparam int OFF_W  = $clog2(`FETCH_BLOCK_BYTES);
    localparam int IDX_W  = $clog2(LINES);
    localparam int TAG_W  = 32 - OFF_W - IDX_W;
    localparam int WOFF_W = OFF_W - 2;

    logic [LINES-1:0] valid;
    logic [TAG_W-1:0] tag_mem [LINES];
    cache_line_t      data_mem [LINES];

    logic [IDX_W-1:0]  lk_idx;
    logic [TAG_W-1:0]  lk_tag;
    logic [WOFF_W-1:0] lk_woff;
    logic [IDX_W-1:0]  fl_idx;
    logic [TAG_W-1:0]  fl_tag;
    logic              lk_match;
    cache_line_t       lk_line;

    // Address split is tag, index, word offset and the byte offset within the word
    assign lk_idx  = lookup_addr[OFF_W +: IDX_W];
    assign lk_tag  = lookup_addr[31 -: TAG_W];
    assign lk_woff = lookup_addr[OFF_W-1:2];

    assign fl_idx = fill_addr[OFF_W +: IDX_W];
    assign fl_tag = fill_addr[31 -: TAG_W];

    assign lk_line  = data_mem[lk_idx];
    assign lk_match = valid[lk_idx] && (tag_mem[lk_idx] == lk_tag);

    // Valid bits start cleared so the first access to every index misses
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid <= '0;
            hit   <= 1'b0;
        end else begin
            if (fill_valid) begin
                valid[fl_idx] <= 1'b1;
            end
            if (lookup_req) begin
                hit <= lk_match;   // Held until the next lookup
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill_valid) begin
            tag_mem[fl_idx]  <= fl_tag;
            data_mem[fl_idx] <= fill_line;
        end
        if (lookup_req) begin
            word <= lk_line[lk_woff*32 +: 32];
        end
    end

endmodule

`default_nettype wire

/* fetch_ifu.sv */
`default_nettype none

`include "fetch_settings.svh"

module fetch_ifu (
    input  wire                         clk,
    input  wire                         rst,
    input  wire  [31:0]                 pc,
    input  wire                         idu_ready,
    output logic                        inst_valid,
    output fetch_pkg::fetch_rsp_t       rsp,
    output logic                        lookup_req,
    output logic [31:0]                 lookup_addr,
    input  wire                         hit,
    input  wire  [31:0]                 word,
    output logic                        fill_valid,
    output logic [31:0]                 fill_addr,
    output fetch_pkg::cache_line_t      fill_line,
    output logic                        arvalid,
    output fetch_pkg::axi_ar_t          ar,
    input  wire                         arready,
    input  wire                         rvalid,
    input  wire  fetch_pkg::axi_r_t     r,
    output logic                        rready
);
    import fetch_pkg::*;

    localparam int OFF_W = $clog2(`FETCH_BLOCK_BYTES);
    localparam int WORDS = `FETCH_BLOCK_BYTES / 4;
    localparam int CNT_W = $clog2(WORDS);

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOOKUP,
        S_CHECK,
        S_REFILL,
        S_DELIVER
    } state_t;

    state_t           state;
    logic [31:0]      last_pc;
    logic [31:0]      line_base;
    logic             burst_mode;
    logic [CNT_W-1:0] beat_cnt;
    logic [CNT_W-1:0] next_cnt;
    logic [CNT_W-1:0] req_off;
    logic             start;
    logic             in_sdram;
    logic             beat;
    logic             beat_err;
    logic             line_done;
    cache_line_t      line_buf;
    cache_line_t      line_next;
    fetch_rsp_t       rsp_q;

    assign start    = (state == S_IDLE) && idu_ready && (pc != last_pc);
    assign in_sdram = (line_base >= `FETCH_SDRAM_BASE) && (line_base <= `FETCH_SDRAM_END);
    assign beat     = rvalid && rready;
    assign beat_err = (r.resp != AXI_RESP_OKAY);
    assign next_cnt = beat_cnt + 1'b1;
    assign req_off  = last_pc[OFF_W-1:2];

    // A burst ends on rlast while single reads end after the last word of the line
    assign line_done = burst_mode ? r.last : (beat_cnt == CNT_W'(WORDS - 1));

    // Current line buffer with the arriving beat merged in
    always_comb begin
        line_next = line_buf;
        line_next[beat_cnt*32 +: 32] = r.data;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= S_IDLE;
            last_pc    <= '0;
            line_base  <= '0;
            burst_mode <= 1'b0;
            beat_cnt   <= '0;
            arvalid    <= 1'b0;
            rready     <= 1'b0;
            fill_valid <= 1'b0;
        end else begin
            fill_valid <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (start) begin
                        last_pc   <= pc;
                        line_base <= {pc[31:OFF_W], {OFF_W{1'b0}}};
                        state     <= S_LOOKUP;
                    end
                end
                S_LOOKUP: begin
                    state <= S_CHECK;   // Cache answers during this cycle
                end
                S_CHECK: begin
                    if (hit) begin
                        state <= idu_ready ? S_IDLE : S_DELIVER;
                    end else begin
                        burst_mode <= in_sdram;
                        beat_cnt   <= '0;
                        arvalid    <= 1'b1;
                        state      <= S_REFILL;
                    end
                end
                S_REFILL: begin
                    if (arvalid && arready) begin
                        arvalid <= 1'b0;
                        rready  <= 1'b1;
                    end
                    if (beat) begin
                        if (beat_err) begin
                            // Fault ends the refill here and the line is dropped
                            rready <= 1'b0;
                            state  <= S_DELIVER;
                        end else if (line_done) begin
                            rready     <= 1'b0;
                            fill_valid <= 1'b1;
                            state      <= S_DELIVER;
                        end else begin
                            beat_cnt <= next_cnt;
                            if (!burst_mode) begin
                                rready  <= 1'b0;
                                arvalid <= 1'b1;   // Next single read of the line
                            end
                        end
                    end
                end
                S_DELIVER: begin
                    if (idu_ready) begin
                        state <= S_IDLE;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            S_CHECK: begin
                if (hit) begin
                    rsp_q <= '{inst: word, access_fault: 1'b0};
                end else begin
                    ar.addr  <= line_base;
                    ar.id    <= `FETCH_AXI_ID;
                    ar.len   <= in_sdram ? 8'(WORDS - 1) : 8'd0;
                    ar.size  <= AXI_SIZE_4B;
                    ar.burst <= in_sdram ? AXI_BURST_INCR : AXI_BURST_FIXED;
                end
            end
            S_REFILL: begin
                if (beat) begin
                    if (beat_err) begin
                        rsp_q <= '{inst: '0, access_fault: 1'b1};
                    end else begin
                        line_buf <= line_next;
                        rsp_q    <= '{inst: line_next[req_off*32 +: 32], access_fault: 1'b0};
                        // Only used when another single read follows
                        ar.addr  <= line_base + (32'(next_cnt) << 2);
                    end
                end
            end
            default: ;
        endcase
    end

    // A hit is offered straight from the cache word so it is valid two cycles after start
    assign inst_valid = ((state == S_CHECK) && hit) || (state == S_DELIVER);

    always_comb begin
        if (state == S_CHECK) begin
            rsp = '{inst: word, access_fault: 1'b0};
        end else begin
            rsp = rsp_q;
        end
    end

    assign lookup_req  = (state == S_LOOKUP);
    assign lookup_addr = last_pc;

    assign fill_addr = line_base;
    assign fill_line = line_buf;

endmodule

`default_nettype wire

/* fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

    `include "fetch_settings.svh"

    // Word k of a line sits at bits 32k and up
    typedef logic [`FETCH_BLOCK_BYTES*8-1:0] cache_line_t;

    typedef struct packed {
        logic [31:0] addr;
        logic [3:0]  id;
        logic [7:0]  len;
        logic [2:0]  size;
        logic [1:0]  burst;
    } axi_ar_t;

    typedef struct packed {
        logic [31:0] data;
        logic [1:0]  resp;
        logic        last;
        logic [3:0]  id;
    } axi_r_t;

    // What decode receives for one fetch
    typedef struct packed {
        logic [31:0] inst;
        logic        access_fault;
    } fetch_rsp_t;

    localparam logic [1:0] AXI_BURST_FIXED = 2'b00;
    localparam logic [1:0] AXI_BURST_INCR  = 2'b01;
    localparam logic [2:0] AXI_SIZE_4B     = 3'b010;
    localparam logic [1:0] AXI_RESP_OKAY   = 2'b00;

endpackage

`default_nettype wire

/* fetch_settings.svh */
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// Line size in bytes must be a multiple of four
`define FETCH_BLOCK_BYTES 16

// Number of lines in the direct-mapped cache must be a power of two
`define FETCH_CACHE_LINES 16

// Window served by the SDRAM controller, the only target that accepts INCR bursts
`define FETCH_SDRAM_BASE 32'hA000_0000
`define FETCH_SDRAM_END  32'hBFFF_FFFF

// Id carried by every AR the fetch unit issues
`define FETCH_AXI_ID 4'h1

`endif

/* fetch_top.sv */
`default_nettype none

module fetch_top (
    input  wire                     clk,
    input  wire                     rst,
    input  wire  [31:0]             pc,
    input  wire                     idu_ready,
    output wire                     inst_valid,
    output wire  fetch_pkg::fetch_rsp_t rsp,
    output wire                     arvalid,
    output wire  fetch_pkg::axi_ar_t ar,
    input  wire                     arready,
    input  wire                     rvalid,
    input  wire  fetch_pkg::axi_r_t r,
    output wire                     rready
);
    import fetch_pkg::*;

    wire              lookup_req;
    wire [31:0]       lookup_addr;
    wire              hit;
    wire [31:0]       word;
    wire              fill_valid;
    wire [31:0]       fill_addr;
    wire cache_line_t fill_line;

    fetch_ifu ifu_i (
        .clk         (clk),
        .rst         (rst),
        .pc          (pc),
        .idu_ready   (idu_ready),
        .inst_valid  (inst_valid),
        .rsp         (rsp),
        .lookup_req  (lookup_req),
        .lookup_addr (lookup_addr),
        .hit         (hit),
        .word        (word),
        .fill_valid  (fill_valid),
        .fill_addr   (fill_addr),
        .fill_line   (fill_line),
        .arvalid     (arvalid),
        .ar          (ar),
        .arready     (arready),
        .rvalid      (rvalid),
        .r           (r),
        .rready      (rready)
    );

    fetch_icache icache_i (
        .clk         (clk),
        .rst         (rst),
        .lookup_req  (lookup_req),
        .lookup_addr (lookup_addr),
        .hit         (hit),
        .word        (word),
        .fill_valid  (fill_valid),
        .fill_addr   (fill_addr),
        .fill_line   (fill_line)
    );

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Builds the testbench with Verilator and runs it; the exit status is the result
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal --top-module tb_fetch -f fetch.f -o tb_fetch_sim &&
./obj_dir/tb_fetch_sim || {
    echo "Simulation failed"
    exit 1
}

/* tb_axi_mem.sv */
`default_nettype none

`include "fetch_settings.svh"

module tb_axi_mem (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         arvalid,
    input  wire  fetch_pkg::axi_ar_t    ar,
    output logic                        arready,
    output logic                        rvalid,
    output fetch_pkg::axi_r_t           r,
    input  wire                         rready,
    input  wire  [1:0]                  stall,
    input  wire                         fetch_start,
    input  wire  [31:0]                 exp_base,
    output int                          ar_count,
    output logic                        error
);
    import fetch_pkg::*;

    // Words in this range answer with SLVERR
    localparam logic [31:0] ERR_LO = 32'h0000_3004;
    localparam logic [31:0] ERR_HI = 32'h0000_30FF;

    axi_ar_t     cur;
    axi_ar_t     ar_prev;
    logic        busy;
    logic        ar_hold;
    logic        r_hold;
    logic [1:0]  stall_q;
    logic [31:0] beat_addr;
    int          beat_idx;
    int          ar_in_fetch;

    function automatic logic [31:0] word_at(input logic [31:0] addr);
        return {addr[15:0], addr[31:16]} ^ 32'h9e37_79b9;
    endfunction

    function automatic logic in_window(input logic [31:0] addr);
        return (addr >= `FETCH_SDRAM_BASE) && (addr <= `FETCH_SDRAM_END);
    endfunction

    // The k-th AR of a fetch whose line starts at base
    function automatic axi_ar_t expected_ar(input logic [31:0] base, input int k);
        axi_ar_t a;
        a.id   = `FETCH_AXI_ID;
        a.size = AXI_SIZE_4B;
        if (in_window(base)) begin
            a.addr  = base;
            a.len   = 8'(`FETCH_BLOCK_BYTES / 4 - 1);
            a.burst = AXI_BURST_INCR;
        end else begin
            a.addr  = base + 32'(4 * k);
            a.len   = 8'd0;
            a.burst = AXI_BURST_FIXED;
        end
        return a;
    endfunction

    task automatic check_ar(input string name, input axi_ar_t exp, input axi_ar_t act);
        if (act !== exp) begin
            $display("Fail %s: expected %h, actual %h", name, exp, act);
            error = 1'b1;
        end
    endtask

    task automatic report_protocol(input string what);
        $display("Error: %s", what);
        error = 1'b1;
    endtask

    initial begin
        arready     = 1'b0;
        rvalid      = 1'b0;
        r           = '0;
        error       = 1'b0;
        ar_count    = 0;
        ar_in_fetch = 0;
        busy        = 1'b0;
        ar_hold     = 1'b0;
        r_hold      = 1'b0;
        forever begin
            @(posedge clk);
            if (rst) begin
                busy     = 1'b0;
                ar_hold  = 1'b0;
                ar_count = 0;
                #2;
                arready = 1'b0;
                rvalid  = 1'b0;
            end else begin
                stall_q = stall;   // Taken at the edge, stable since the last drive
                if (fetch_start) begin
                    ar_in_fetch = 0;
                end
                if (ar_hold && (!arvalid || ar !== ar_prev)) begin
                    report_protocol("AR payload changed or arvalid dropped before arready");
                end
                if (rready && !busy) begin
                    report_protocol("rready is high with no read outstanding");
                end
                if (arvalid && busy) begin
                    report_protocol("arvalid was raised while a read was outstanding");
                end
                r_hold = rvalid && !rready;
                if (arvalid && arready) begin
                    check_ar($sformatf("ar %0d", ar_count), expected_ar(exp_base, ar_in_fetch), ar);
                    cur         = ar;
                    busy        = 1'b1;
                    beat_idx    = 0;
                    ar_count    = ar_count + 1;
                    ar_in_fetch = ar_in_fetch + 1;
                end else if (rvalid && rready) begin
                    beat_idx = beat_idx + 1;
                    // The fetch unit stops listening after an error beat
                    if (beat_idx > int'(cur.len) || r.resp != AXI_RESP_OKAY) begin
                        busy = 1'b0;
                    end
                end
                ar_hold = arvalid && !arready;
                ar_prev = ar;
                #2;
                arready = !busy && !stall_q[0];
                if (!r_hold) begin
                    if (busy && !stall_q[1]) begin
                        beat_addr = (cur.burst == AXI_BURST_INCR) ?
                                    cur.addr + 32'(4 * beat_idx) : cur.addr;
                        r.data = word_at(beat_addr);
                        r.resp = (beat_addr >= ERR_LO && beat_addr <= ERR_HI) ?
                                 2'b10 : AXI_RESP_OKAY;
                        r.last = (beat_idx == int'(cur.len));
                        r.id   = cur.id;
                        rvalid = 1'b1;
                    end else begin
                        rvalid = 1'b0;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

/* tb_fetch.sv */
`default_nettype none

`include "fetch_settings.svh"

module tb_fetch;
    import fetch_pkg::*;

    localparam logic [31:0] SEED     = 32'hdf7e_1fcf;
    localparam logic [31:0] ERR_LO   = 32'h0000_3004;
    localparam logic [31:0] ERR_HI   = 32'h0000_30FF;
    localparam int          TIMEOUT  = 200;
    localparam int          N_RANDOM = 300;
    localparam int          OFF_W    = $clog2(`FETCH_BLOCK_BYTES);
    localparam int          IDX_W    = $clog2(`FETCH_CACHE_LINES);
    localparam int          WORDS    = `FETCH_BLOCK_BYTES / 4;

    // Half in the SDRAM window, half low, with several lines sharing an index
    localparam logic [31:0] POOL [16] = '{
        32'hA000_0004, 32'hA000_0008, 32'hA000_1008, 32'hA000_0050,
        32'hB000_005C, 32'hA000_00F0, 32'hBFFF_FFFC, 32'hA000_0024,
        32'h0000_1000, 32'h0000_1014, 32'h0000_2014, 32'h0000_10F8,
        32'h0000_3004, 32'h0000_3018, 32'h0000_1024, 32'h0000_0C28
    };

    logic        clk;
    logic        rst;
    logic [31:0] pc;
    logic        idu_ready;
    logic        inst_valid;
    fetch_rsp_t  rsp;
    logic        arvalid;
    axi_ar_t     ar;
    logic        arready;
    logic        rvalid;
    axi_r_t      r;
    logic        rready;
    logic [1:0]  stall;
    logic        fetch_start;
    logic [31:0] exp_base;
    int          ar_count;
    logic        mem_error;

    logic [31:0] rng;
    logic [31:0] delay_rng;
    logic        model_valid [`FETCH_CACHE_LINES];
    logic [31:0] model_tag [`FETCH_CACHE_LINES];
    logic [31:0] model_last_pc;

    fetch_top dut_i (
        .clk        (clk),
        .rst        (rst),
        .pc         (pc),
        .idu_ready  (idu_ready),
        .inst_valid (inst_valid),
        .rsp        (rsp),
        .arvalid    (arvalid),
        .ar         (ar),
        .arready    (arready),
        .rvalid     (rvalid),
        .r          (r),
        .rready     (rready)
    );

    tb_axi_mem mem_i (
        .clk         (clk),
        .rst         (rst),
        .arvalid     (arvalid),
        .ar          (ar),
        .arready     (arready),
        .rvalid      (rvalid),
        .r           (r),
        .rready      (rready),
        .stall       (stall),
        .fetch_start (fetch_start),
        .exp_base    (exp_base),
        .ar_count    (ar_count),
        .error       (mem_error)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    function automatic logic [31:0] next_rand(input logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        return s ^ (s << 5);
    endfunction

    function automatic logic [31:0] word_at(input logic [31:0] addr);
        return {addr[15:0], addr[31:16]} ^ 32'h9e37_79b9;
    endfunction

    function automatic logic in_window(input logic [31:0] addr);
        return (addr >= `FETCH_SDRAM_BASE) && (addr <= `FETCH_SDRAM_END);
    endfunction

    function automatic logic in_error_range(input logic [31:0] addr);
        return (addr >= ERR_LO) && (addr <= ERR_HI);
    endfunction

    // Slave delays come from their own stream so they do not shift the pc sequence
    always @(posedge clk) begin
        #2;
        delay_rng = next_rand(delay_rng);
        stall     = {delay_rng[7:6] == 2'b00, delay_rng[1:0] == 2'b00};
    end

    task automatic tick();
        @(posedge clk);
        #2;
    endtask

    task automatic abort_run();
        $display("Some tests failed");
        $fatal(1, "Stopped at the first error");
    endtask

    always @(posedge mem_error) begin
        abort_run();
    end

    task automatic check_rsp(input string name, input fetch_rsp_t exp, input fetch_rsp_t act);
        if (act !== exp) begin
            $display("Fail %s: expected inst %h fault %0b, actual inst %h fault %0b",
                     name, exp.inst, exp.access_fault, act.inst, act.access_fault);
            abort_run();
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("Fail %s: expected %0d, actual %0d", name, exp, act);
            abort_run();
        end
    endtask

    task automatic drive_ready(input logic stalls);
        rng       = next_rand(rng);
        idu_ready = stalls ? (rng[1:0] != 2'b00) : 1'b1;
    endtask

    // Holds pc and expects the fetch unit to stay quiet
    task automatic check_idle(input string name, input int n);
        int start;
        int i;
        start = ar_count;
        for (i = 0; i < n; i++) begin
            tick();
            check_count({name, " inst_valid"}, 0, int'(inst_valid));
            check_count({name, " arvalid"}, 0, int'(arvalid));
        end
        check_count({name, " ar count"}, 0, ar_count - start);
    endtask

    task automatic run_fetch(input string name, input logic [31:0] addr, input logic stalls);
        logic [31:0] base;
        logic [31:0] tag;
        int          idx;
        int          k;
        logic        hit;
        logic        fault;
        int          exp_ars;
        int          ar_start;
        int          cycles;
        fetch_rsp_t  exp_rsp;
        base    = addr & ~32'(`FETCH_BLOCK_BYTES - 1);
        idx     = int'(addr[OFF_W +: IDX_W]);
        tag     = addr >> (OFF_W + IDX_W);
        hit     = model_valid[idx] && (model_tag[idx] == tag);
        fault   = 1'b0;
        exp_ars = 0;
        if (!hit) begin
            exp_ars = in_window(base) ? 1 : WORDS;
            for (k = 0; k < WORDS; k++) begin
                if (!fault && in_error_range(base + 32'(4 * k))) begin
                    fault = 1'b1;
                    if (!in_window(base)) begin
                        exp_ars = k + 1;   // Single reads stop at the failing word
                    end
                end
            end
        end
        exp_rsp.inst         = fault ? 32'h0 : word_at(addr);
        exp_rsp.access_fault = fault;

        ar_start    = ar_count;
        pc          = addr;
        exp_base    = base;
        idu_ready   = 1'b1;
        fetch_start = 1'b1;
        cycles      = 0;
        while (!inst_valid && cycles < TIMEOUT) begin
            tick();
            fetch_start = 1'b0;
            cycles++;
            drive_ready(stalls);
        end
        if (!inst_valid) begin
            $display("Error: %s timed out waiting for inst_valid", name);
            abort_run();
        end
        if (hit) begin
            check_count({name, " hit latency"}, 2, cycles);
        end
        check_rsp(name, exp_rsp, rsp);

        cycles = 0;
        while (!idu_ready && cycles < TIMEOUT) begin
            tick();
            cycles++;
            drive_ready(stalls);
            check_count({name, " inst_valid held"}, 1, int'(inst_valid));
            check_rsp({name, " held"}, exp_rsp, rsp);
        end
        if (!idu_ready) begin
            $display("Error: %s timed out waiting for decode to accept", name);
            abort_run();
        end
        tick();
        check_count({name, " inst_valid after accept"}, 0, int'(inst_valid));
        check_count({name, " ar count"}, exp_ars, ar_count - ar_start);

        if (!hit && !fault) begin
            model_valid[idx] = 1'b1;   // A faulted line never reaches the cache
            model_tag[idx]   = tag;
        end
        model_last_pc = addr;
        check_idle({name, " repeat pc"}, 2);
    endtask

    initial begin
        int          i;
        logic [31:0] addr;
        rst         = 1'b1;
        pc          = 32'h0;
        idu_ready   = 1'b0;
        stall       = 2'b00;
        fetch_start = 1'b0;
        exp_base    = 32'h0;
        rng         = SEED;
        delay_rng   = next_rand(SEED);
        for (i = 0; i < `FETCH_CACHE_LINES; i++) begin
            model_valid[i] = 1'b0;
            model_tag[i]   = 32'h0;
        end
        model_last_pc = 32'h0;

        repeat (5) @(posedge clk);
        #2;
        rst       = 1'b0;
        idu_ready = 1'b1;
        check_idle("reset", 4);   // pc 0 equals the reset value of the last address

        run_fetch("sdram miss", 32'hA000_0004, 1'b0);
        run_fetch("low miss", 32'h0000_1014, 1'b0);
        run_fetch("sdram hit", 32'hA000_0008, 1'b0);
        run_fetch("low hit", 32'h0000_1018, 1'b0);
        run_fetch("fault mid line", 32'h0000_3004, 1'b0);
        run_fetch("fault refetch", 32'h0000_3008, 1'b0);
        run_fetch("fault first word", 32'h0000_3018, 1'b0);
        run_fetch("alias evict", 32'hA000_1008, 1'b0);
        run_fetch("alias refetch", 32'hA000_0004, 1'b0);

        for (i = 0; i < N_RANDOM; i++) begin
            rng  = next_rand(rng);
            addr = POOL[rng[11:8]];
            if (addr == model_last_pc) begin
                pc        = addr;
                idu_ready = 1'b1;
                check_idle($sformatf("random %0d same pc", i), 4);
            end else begin
                run_fetch($sformatf("random %0d", i), addr, 1'b1);
            end
        end

        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire
